/* hdl/noncomp_pkg.sv */
// Shared definitions for the non-computational FP slice
// Formats, operation encoding, datapath types and pipeline depth
// for a two-lane FP32/FP16 SIMD slice

package noncomp_pkg;

  // ----------------------------------------
  // Datapath geometry
  // ----------------------------------------
  localparam int unsigned WIDTH         = 32;
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned TAG_BITS      = 4;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MINM  = 3'd3,
    MAXM  = 3'd4
  } noncomp_op_e;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic [WIDTH-1:0]     operand_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;  // One bit per lane
  typedef logic [4:0]           status_t;     // {NV, DZ, OF, UF, NX}
  typedef logic [TAG_BITS-1:0]  tag_t;
  typedef logic [1:0]           aux_t;        // {vectorial, format}

  // Quiet NaN with only the MSB of the mantissa set
  localparam operand_t    CANON_NAN32 = 32'h7fc0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7e00;

endpackage

/* hdl/lane_splitter.sv */
`timescale 1ns/1ps
// Lane splitter
// Slices the operand words into per-lane operands by format,
// replaces badly boxed scalar FP16 operands with the canonical NaN
// and decides which lanes take part in the operation

module lane_splitter (
  input  noncomp_pkg::operand_t [1:0]                        operands_i,
  input  noncomp_pkg::fp_format_e                            fmt_i,
  input  logic                                               vectorial_i,
  input  logic                                               in_valid_i,
  output noncomp_pkg::operand_t [noncomp_pkg::NUM_LANES-1:0] lane_a_o,
  output noncomp_pkg::operand_t [noncomp_pkg::NUM_LANES-1:0] lane_b_o,
  output noncomp_pkg::lane_mask_t                            lane_active_o,
  output noncomp_pkg::aux_t                                  aux_o
);
  import noncomp_pkg::*;

  logic           fp16_vec;
  logic           fp16_scalar;
  logic     [1:0] boxed;     // Upper half all ones, per operand
  operand_t [1:0] lane0_op;
  operand_t [1:0] lane1_op;

  assign fp16_vec    = (fmt_i == FP16) & vectorial_i;
  assign fp16_scalar = (fmt_i == FP16) & ~vectorial_i;

  // ----------------------------------------
  // Operand slicing
  // ----------------------------------------
  always_comb begin : slice_lanes
    for (int i = 0; i < 2; i++) begin
      boxed[i]    = &operands_i[i][WIDTH-1:WIDTH/2];
      lane0_op[i] = operands_i[i];
      // A scalar FP16 value is only trusted when NaN-boxed
      if (fp16_scalar && !boxed[i]) begin
        lane0_op[i] = {16'hffff, CANON_NAN16};
      end
      // Upper lane sees the upper halves, held at zero otherwise
      lane1_op[i] = fp16_vec ? {16'hffff, operands_i[i][WIDTH-1:WIDTH/2]} : '0;
    end
  end

  assign lane_a_o[0] = lane0_op[0];
  assign lane_b_o[0] = lane0_op[1];
  assign lane_a_o[1] = lane1_op[0];
  assign lane_b_o[1] = lane1_op[1];

  // Lane 1 only works on valid FP16 vectors
  assign lane_active_o = {in_valid_i & fp16_vec, in_valid_i};

  // Format info travels with the data to the packer
  assign aux_o = {fp16_vec, fmt_i};

endmodule

/* hdl/noncomp_lane.sv */
`timescale 1ns/1ps
// Non-computational FP lane
// Sign injection and minimum/maximum on one FP32 or FP16 value,
// raising NV for signaling NaN inputs to MINM and MAXM

module noncomp_lane #(
  parameter bit SupportsFp32 = 1'b1
) (
  input  noncomp_pkg::operand_t    a_i,
  input  noncomp_pkg::operand_t    b_i,
  input  noncomp_pkg::noncomp_op_e op_i,
  input  noncomp_pkg::fp_format_e  fmt_i,
  output noncomp_pkg::operand_t    result_o,
  output noncomp_pkg::status_t     status_o
);
  import noncomp_pkg::*;

  // Returns {is_nan, is_snan}
  function automatic logic [1:0] nan_class(input operand_t x, input logic fp32);
    logic exp_max;
    logic man_nz;
    logic quiet;
    if (fp32) begin
      exp_max = &x[30:23];
      man_nz  = |x[22:0];
      quiet   = x[22];
    end else begin
      exp_max = &x[14:10];
      man_nz  = |x[9:0];
      quiet   = x[9];
    end
    return {exp_max & man_nz, exp_max & man_nz & ~quiet};
  endfunction

  logic        is_fp32;
  operand_t    a_w;
  operand_t    b_w;
  logic [1:0]  a_cls;
  logic [1:0]  b_cls;
  logic        sign_a;
  logic        sign_b;
  logic        sign_inj;
  logic [30:0] mag_a;
  logic [30:0] mag_b;
  logic        a_less;
  logic        is_minmax;
  operand_t    canon_nan;
  operand_t    sgnj_res;
  operand_t    minmax_res;

  assign is_fp32 = SupportsFp32 && (fmt_i == FP32);

  // FP16 values are boxed inside the lane so results leave boxed
  assign a_w = is_fp32 ? a_i : {16'hffff, a_i[15:0]};
  assign b_w = is_fp32 ? b_i : {16'hffff, b_i[15:0]};

  assign a_cls  = nan_class(a_w, is_fp32);
  assign b_cls  = nan_class(b_w, is_fp32);
  assign sign_a = is_fp32 ? a_w[31] : a_w[15];
  assign sign_b = is_fp32 ? b_w[31] : b_w[15];
  assign mag_a  = is_fp32 ? a_w[30:0] : {16'b0, a_w[14:0]};
  assign mag_b  = is_fp32 ? b_w[30:0] : {16'b0, b_w[14:0]};

  // ----------------------------------------
  // Sign injection
  // ----------------------------------------
  always_comb begin : sign_inject
    case (op_i)
      SGNJN:   sign_inj = ~sign_b;
      SGNJX:   sign_inj = sign_a ^ sign_b;
      default: sign_inj = sign_b;
    endcase
    if (is_fp32) begin
      sgnj_res = {sign_inj, a_w[30:0]};
    end else begin
      sgnj_res = {a_w[31:16], sign_inj, a_w[14:0]};
    end
  end

  // ----------------------------------------
  // Minimum / maximum
  // ----------------------------------------
  // Differing signs decide alone, so -0 orders below +0
  assign a_less = (sign_a != sign_b) ? sign_a :
                  sign_a             ? (mag_a > mag_b) : (mag_a < mag_b);

  assign canon_nan = is_fp32 ? CANON_NAN32 : {16'hffff, CANON_NAN16};

  always_comb begin : min_max
    if (a_cls[1] && b_cls[1]) begin
      minmax_res = canon_nan;
    end else if (a_cls[1]) begin
      minmax_res = b_w;            // NaN loses against a number
    end else if (b_cls[1]) begin
      minmax_res = a_w;
    end else if ((op_i == MINM) == a_less) begin
      minmax_res = a_w;
    end else begin
      minmax_res = b_w;
    end
  end

  assign is_minmax = (op_i == MINM) || (op_i == MAXM);
  assign result_o  = is_minmax ? minmax_res : sgnj_res;
  assign status_o  = {is_minmax & (a_cls[0] | b_cls[0]), 4'b0};

  // The top level parks an idle FP16-only lane on FP16
  a_fp16_only: assert final (SupportsFp32 || fmt_i == FP16)
    else $error("FP32 operation reached an FP16-only lane");

endmodule

/* hdl/lane_pipeline.sv */
`timescale 1ns/1ps
// Lane pipeline
// Register stages with valid/ready handshake and flush, carrying the
// lane results, status, lane mask, aux bits and tag in lockstep

module lane_pipeline (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  logic                                               in_valid_i,
  input  logic                                               flush_i,
  input  logic                                               out_ready_i,
  input  noncomp_pkg::operand_t [noncomp_pkg::NUM_LANES-1:0] lane_res_i,
  input  noncomp_pkg::status_t  [noncomp_pkg::NUM_LANES-1:0] lane_status_i,
  input  noncomp_pkg::lane_mask_t                            lane_mask_i,
  input  noncomp_pkg::aux_t                                  aux_i,
  input  noncomp_pkg::tag_t                                  tag_i,
  output logic                                               in_ready_o,
  output logic                                               out_valid_o,
  output logic                                               busy_o,
  output noncomp_pkg::operand_t [noncomp_pkg::NUM_LANES-1:0] lane_res_o,
  output noncomp_pkg::status_t  [noncomp_pkg::NUM_LANES-1:0] lane_status_o,
  output noncomp_pkg::lane_mask_t                            lane_mask_o,
  output noncomp_pkg::aux_t                                  aux_o,
  output noncomp_pkg::tag_t                                  tag_o
);
  import noncomp_pkg::*;

  // Entry i holds the item after i register stages
  operand_t [NUM_LANES-1:0] res_q    [NUM_PIPE_REGS+1];
  status_t  [NUM_LANES-1:0] status_q [NUM_PIPE_REGS+1];
  lane_mask_t               mask_q   [NUM_PIPE_REGS+1];
  aux_t                     aux_q    [NUM_PIPE_REGS+1];
  tag_t                     tag_q    [NUM_PIPE_REGS+1];
  logic                     valid_q  [NUM_PIPE_REGS+1];
  logic                     ready    [NUM_PIPE_REGS+1];  // Combinational, per stage

  assign valid_q[0]  = in_valid_i;
  assign res_q[0]    = lane_res_i;
  assign status_q[0] = lane_status_i;
  assign mask_q[0]   = lane_mask_i;
  assign aux_q[0]    = aux_i;
  assign tag_q[0]    = tag_i;

  // ----------------------------------------
  // Register stages
  // ----------------------------------------
  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stages
    logic reg_ena;

    // Advance when the next stage moves on or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign reg_ena  = ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
      if (!arst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (reg_ena) begin
        res_q[i+1]    <= res_q[i];
        status_q[i+1] <= status_q[i];
        mask_q[i+1]   <= mask_q[i];
        aux_q[i+1]    <= aux_q[i];
        tag_q[i+1]    <= tag_q[i];
      end
    end
  end

  // Ready enters from the downstream side
  assign ready[NUM_PIPE_REGS] = out_ready_i;
  assign in_ready_o           = ready[0];

  assign out_valid_o   = valid_q[NUM_PIPE_REGS];
  assign lane_res_o    = res_q[NUM_PIPE_REGS];
  assign lane_status_o = status_q[NUM_PIPE_REGS];
  assign lane_mask_o   = mask_q[NUM_PIPE_REGS];
  assign aux_o         = aux_q[NUM_PIPE_REGS];
  assign tag_o         = tag_q[NUM_PIPE_REGS];

  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int i = 1; i <= NUM_PIPE_REGS; i++) begin
      busy_o |= valid_q[i];
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(lane_res_o) && $stable(lane_status_o) &&
      $stable(lane_mask_o) && $stable(aux_o) && $stable(tag_o))
    else $error("Output changed while stalled");

  // A flush leaves every stage empty in the next cycle
  a_flush_empties: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !busy_o && !out_valid_o)
    else $error("Pipeline not empty after flush");

endmodule

/* hdl/result_packer.sv */
`timescale 1ns/1ps
// Result packer
// Assembles the output word from the lane results by format,
// NaN-boxes unused upper bits and merges lane status under the mask

module result_packer (
  input  noncomp_pkg::operand_t [noncomp_pkg::NUM_LANES-1:0] lane_res_i,
  input  noncomp_pkg::status_t  [noncomp_pkg::NUM_LANES-1:0] lane_status_i,
  input  noncomp_pkg::lane_mask_t                            lane_mask_i,
  input  noncomp_pkg::aux_t                                  aux_i,
  output noncomp_pkg::operand_t                              result_o,
  output noncomp_pkg::status_t                               status_o
);
  import noncomp_pkg::*;

  logic       res_vec;
  fp_format_e res_fmt;

  assign res_vec = aux_i[1];
  assign res_fmt = fp_format_e'(aux_i[0]);

  // ----------------------------------------
  // Result packing
  // ----------------------------------------
  always_comb begin : pack_result
    if (res_fmt == FP32) begin
      result_o = lane_res_i[0];
    end else if (res_vec) begin
      result_o = {lane_res_i[1][WIDTH/2-1:0], lane_res_i[0][WIDTH/2-1:0]};
    end else begin
      result_o = {{(WIDTH/2){1'b1}}, lane_res_i[0][WIDTH/2-1:0]};  // NaN-box
    end
  end

  // Masked-off lanes keep their result but lose their flags
  always_comb begin : collapse_status
    status_o = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      status_o |= lane_status_i[l] & {$bits(status_t){lane_mask_i[l]}};
    end
  end

endmodule

/* hdl/noncomp_slice.sv */
`timescale 1ns/1ps
// Non-computational FP slice
// Two-lane SIMD unit for sign injection and min/max on FP32 and FP16,
// with a valid/ready pipeline, flush, tag and busy indication

module noncomp_slice (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  noncomp_pkg::operand_t [1:0]     operands_i,
  input  noncomp_pkg::noncomp_op_e        op_i,
  input  noncomp_pkg::fp_format_e         fmt_i,
  input  logic                            vectorial_i,
  input  noncomp_pkg::tag_t               tag_i,
  input  noncomp_pkg::lane_mask_t         simd_mask_i,
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  logic                            flush_i,
  output noncomp_pkg::operand_t           result_o,
  output noncomp_pkg::status_t            status_o,
  output noncomp_pkg::tag_t               tag_o,
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output logic                            busy_o
);
  import noncomp_pkg::*;

  operand_t [NUM_LANES-1:0] lane_a;
  operand_t [NUM_LANES-1:0] lane_b;
  operand_t [NUM_LANES-1:0] lane_res;
  status_t  [NUM_LANES-1:0] lane_status;
  lane_mask_t               lane_active;
  lane_mask_t               lane_mask;
  aux_t                     aux;
  operand_t [NUM_LANES-1:0] pipe_res;
  status_t  [NUM_LANES-1:0] pipe_status;
  lane_mask_t               pipe_mask;
  aux_t                     pipe_aux;

  lane_splitter i_lane_splitter (
    .operands_i    ( operands_i  ),
    .fmt_i         ( fmt_i       ),
    .vectorial_i   ( vectorial_i ),
    .in_valid_i    ( in_valid_i  ),
    .lane_a_o      ( lane_a      ),
    .lane_b_o      ( lane_b      ),
    .lane_active_o ( lane_active ),
    .aux_o         ( aux         )
  );

  // ----------------------------------------
  // Compute lanes
  // ----------------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    fp_format_e lane_fmt;

    // Idle upper lane sits on FP16, the only format it implements
    assign lane_fmt = (l == 0 || lane_active[l]) ? fmt_i : FP16;

    noncomp_lane #(
      .SupportsFp32 ( l == 0 )
    ) i_noncomp_lane (
      .a_i      ( lane_a[l]      ),
      .b_i      ( lane_b[l]      ),
      .op_i     ( op_i           ),
      .fmt_i    ( lane_fmt       ),
      .result_o ( lane_res[l]    ),
      .status_o ( lane_status[l] )
    );
  end

  assign lane_mask = lane_active & simd_mask_i;

  lane_pipeline i_lane_pipeline (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .in_valid_i    ( in_valid_i  ),
    .flush_i       ( flush_i     ),
    .out_ready_i   ( out_ready_i ),
    .lane_res_i    ( lane_res    ),
    .lane_status_i ( lane_status ),
    .lane_mask_i   ( lane_mask   ),
    .aux_i         ( aux         ),
    .tag_i         ( tag_i       ),
    .in_ready_o    ( in_ready_o  ),
    .out_valid_o   ( out_valid_o ),
    .busy_o        ( busy_o      ),
    .lane_res_o    ( pipe_res    ),
    .lane_status_o ( pipe_status ),
    .lane_mask_o   ( pipe_mask   ),
    .aux_o         ( pipe_aux    ),
    .tag_o         ( tag_o       )
  );

  result_packer i_result_packer (
    .lane_res_i    ( pipe_res    ),
    .lane_status_i ( pipe_status ),
    .lane_mask_i   ( pipe_mask   ),
    .aux_i         ( pipe_aux    ),
    .result_o      ( result_o    ),
    .status_o      ( status_o    )
  );

endmodule

/* include/noncomp_ref.svh */
// Reference model for the non-computational FP slice
// Expected result and status for sign injection and min/max
// on FP32 and scalar or vector FP16, packing included

`ifndef NONCOMP_REF_SVH
`define NONCOMP_REF_SVH

// Returns {is_nan, is_snan}
function automatic logic [1:0] ref_class(input logic fp32, input logic [31:0] x);
  logic nan;
  if (fp32) begin
    nan = (x[30:23] == 8'hff) && (x[22:0] != '0);
    return {nan, nan && !x[22]};  // Quiet bit is the mantissa MSB
  end
  nan = (x[14:10] == 5'h1f) && (x[9:0] != '0);
  return {nan, nan && !x[9]};
endfunction

// Unsigned key with the same order as the FP value, -0 below +0
function automatic logic [32:0] ref_key(input logic fp32, input logic [31:0] x);
  logic        s;
  logic [31:0] mag;
  s   = fp32 ? x[31] : x[15];
  mag = fp32 ? {1'b0, x[30:0]} : {17'b0, x[14:0]};
  return s ? {1'b0, ~mag} : {1'b1, mag};
endfunction

// One lane, FP16 results come back NaN-boxed
function automatic void ref_lane(input noncomp_pkg::noncomp_op_e op, input logic fp32,
                                 input logic [31:0] a, input logic [31:0] b,
                                 output logic [31:0] res, output logic nv);
  logic [1:0] ca;
  logic [1:0] cb;
  logic       sb;
  logic       s;
  logic       take_a;
  ca     = ref_class(fp32, a);
  cb     = ref_class(fp32, b);
  sb     = fp32 ? b[31] : b[15];
  nv     = 1'b0;
  take_a = (ref_key(fp32, a) < ref_key(fp32, b)) == (op == noncomp_pkg::MINM);
  if (op == noncomp_pkg::MINM || op == noncomp_pkg::MAXM) begin
    nv = ca[0] | cb[0];
    if (ca[1] && cb[1]) begin
      res = fp32 ? noncomp_pkg::CANON_NAN32 : {16'hffff, noncomp_pkg::CANON_NAN16};
    end else if (ca[1] || (!cb[1] && !take_a)) begin
      res = b;
    end else begin
      res = a;
    end
  end else begin
    s = (op == noncomp_pkg::SGNJN) ? ~sb :
        (op == noncomp_pkg::SGNJX) ? (sb ^ (fp32 ? a[31] : a[15])) : sb;
    res = a;
    if (fp32) begin
      res[31] = s;
    end else begin
      res[15] = s;
    end
  end
  if (!fp32) begin
    res[31:16] = 16'hffff;
  end
endfunction

// Whole slice: boxing check, both lanes, packing and masked status
function automatic void ref_slice(input noncomp_pkg::noncomp_op_e op,
                                  input noncomp_pkg::fp_format_e fmt, input logic vec,
                                  input logic [1:0] mask, input logic [31:0] a,
                                  input logic [31:0] b, output logic [31:0] res,
                                  output logic [4:0] status);
  logic        fp32;
  logic        is_vec;
  logic [31:0] a0;
  logic [31:0] b0;
  logic [31:0] r0;
  logic [31:0] r1;
  logic        nv0;
  logic        nv1;
  fp32   = (fmt == noncomp_pkg::FP32);
  is_vec = vec & ~fp32;
  a0     = a;
  b0     = b;
  if (!fp32 && !vec && a[31:16] != 16'hffff) begin
    a0[15:0] = noncomp_pkg::CANON_NAN16;
  end
  if (!fp32 && !vec && b[31:16] != 16'hffff) begin
    b0[15:0] = noncomp_pkg::CANON_NAN16;
  end
  ref_lane(op, fp32, a0, b0, r0, nv0);
  ref_lane(op, 1'b0, a >> 16, b >> 16, r1, nv1);
  if (fp32) begin
    res = r0;
  end else begin
    res = {(is_vec ? r1[15:0] : 16'hffff), r0[15:0]};
  end
  status = {(nv0 & mask[0]) | (nv1 & mask[1] & is_vec), 4'b0};
endfunction

`endif

/* testbench/tb_noncomp_slice.sv */
`timescale 1ns/1ps
// Testbench for the non-computational FP slice
// Sign injection, min/max specials, NaN-boxing, vectors with masks,
// back-pressure, latency and flush, checked against a reference model

module tb_noncomp_slice;
  import noncomp_pkg::*;

  `include "noncomp_ref.svh"

  localparam int N_SGNJ    = 40;
  localparam int N_MINMAX  = 256;  // 2 formats x 2 ops x 8 x 8 specials
  localparam int N_BOX     = 40;
  localparam int N_VEC     = 40;
  localparam int N_BP      = 60;
  localparam int N_LAT     = 20;
  localparam int N_FLUSH   = 2;
  localparam int NUM_ITEMS = N_SGNJ + N_MINMAX + N_BOX + N_VEC + N_BP + N_LAT + N_FLUSH;

  logic           clk;
  logic           arst_n;
  operand_t [1:0] operands;
  noncomp_op_e    op;
  fp_format_e     fmt;
  logic           vectorial;
  tag_t           tag;
  lane_mask_t     simd_mask;
  logic           in_valid;
  logic           in_ready;
  logic           flush;
  operand_t       result;
  status_t        status;
  tag_t           tag_out;
  logic           out_valid;
  logic           out_ready;
  logic           busy;

  integer seed = 32'he132f114;
  int     ready_mode;  // 0 high, 1 random, 2 low
  int     cycle;
  int     n_errors;
  int     n_checked;
  int     n_tests;
  int     test_err0;

  // Expected items in acceptance order
  logic [31:0] exp_res_q [$];
  logic [4:0]  exp_st_q  [$];
  tag_t        exp_tag_q [$];
  int          acc_cyc_q [$];  // -1 when latency is not checked

  noncomp_slice i_dut (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .operands_i  ( operands  ),
    .op_i        ( op        ),
    .fmt_i       ( fmt       ),
    .vectorial_i ( vectorial ),
    .tag_i       ( tag       ),
    .simd_mask_i ( simd_mask ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( tag_out   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    n_errors++;
    $display("ERROR t=%0t %s expected %h actual %h", $time, sig, exp_v, act_v);
  endtask

  // Directed specials, FP16 values come NaN-boxed
  function automatic operand_t special_value(input logic fp32, input int idx);
    case (idx)
      0:       return fp32 ? 32'h7fc0_0000 : 32'hffff_7e00;  // Quiet NaN
      1:       return fp32 ? 32'h7f80_0001 : 32'hffff_7c01;  // Signaling NaN
      2:       return fp32 ? 32'h0000_0000 : 32'hffff_0000;
      3:       return fp32 ? 32'h8000_0000 : 32'hffff_8000;
      4:       return fp32 ? 32'h7f80_0000 : 32'hffff_7c00;
      5:       return fp32 ? 32'hff80_0000 : 32'hffff_fc00;
      6:       return fp32 ? 32'h3f80_0000 : 32'hffff_3c00;
      default: return fp32 ? 32'hbf80_0000 : 32'hffff_bc00;
    endcase
  endfunction

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send(input noncomp_op_e o, input fp_format_e f, input logic v,
                      input lane_mask_t m, input operand_t a, input operand_t b);
    op          = o;
    fmt         = f;
    vectorial   = v;
    simd_mask   = m;
    operands[0] = a;
    operands[1] = b;
    in_valid    = 1'b1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    #1;
    in_valid = 1'b0;
    tag      = tag + 1;
  endtask

  task automatic set_ready_mode(input int m);
    ready_mode = m;
    @(posedge clk);
    #1;
  endtask

  task automatic start_test();
    test_err0 = n_errors;
  endtask

  task automatic finish_test(input string name);
    while (exp_res_q.size() != 0 || busy) begin
      @(posedge clk);
      #1;
    end
    n_tests++;
    $display("%s: %0d errors", name, n_errors - test_err0);
  endtask

  // Next ready value is chosen at the edge and driven 1 ns later
  always @(posedge clk) begin : ready_drive
    logic rdy;
    case (ready_mode)
      0:       rdy = 1'b1;
      1:       rdy = ({$random(seed)} % 3) != 0;
      default: rdy = 1'b0;
    endcase
    #1 out_ready = rdy;
  end

  // ----------------------------------------
  // Scoreboard
  // ----------------------------------------
  always @(posedge clk) begin : scoreboard
    logic [31:0] r_res;
    logic [4:0]  r_st;
    int          acc;
    int          pend;
    logic        exp_rdy;
    cycle++;
    if (arst_n) begin
      pend    = exp_res_q.size();
      exp_rdy = (pend < 2) || out_ready;  // Stalls only with both stages full
      if (busy != (pend != 0)) report_mismatch("busy_o", pend != 0, busy);
      if (in_ready != exp_rdy) report_mismatch("in_ready_o", exp_rdy, in_ready);
    end
    if (arst_n && flush) begin
      exp_res_q.delete();  // Flushed items must never appear
      exp_st_q.delete();
      exp_tag_q.delete();
      acc_cyc_q.delete();
    end else if (arst_n) begin
      if (out_valid && out_ready) begin
        if (exp_res_q.size() == 0) begin
          n_errors++;
          $display("ERROR t=%0t output transfer with no item pending", $time);
        end else begin
          n_checked++;
          acc = acc_cyc_q.pop_front();
          if (result != exp_res_q[0]) report_mismatch("result_o", exp_res_q[0], result);
          if (status != exp_st_q[0]) report_mismatch("status_o", exp_st_q[0], status);
          if (tag_out != exp_tag_q[0]) report_mismatch("tag_o", exp_tag_q[0], tag_out);
          if (acc >= 0 && cycle - acc != 2) report_mismatch("latency", 2, cycle - acc);
          void'(exp_res_q.pop_front());
          void'(exp_st_q.pop_front());
          void'(exp_tag_q.pop_front());
        end
      end
      if (in_valid && in_ready) begin
        ref_slice(op, fmt, vectorial, simd_mask, operands[0], operands[1], r_res, r_st);
        exp_res_q.push_back(r_res);
        exp_st_q.push_back(r_st);
        exp_tag_q.push_back(tag);
        acc_cyc_q.push_back(ready_mode == 0 ? cycle : -1);
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    operand_t a;
    operand_t b;
    operand_t v0;
    operand_t v1;
    operand_t v2;
    operand_t v3;
    arst_n     = 1'b0;
    operands   = '0;
    op         = SGNJ;
    fmt        = FP32;
    vectorial  = 1'b0;
    tag        = '0;
    simd_mask  = 2'b11;
    in_valid   = 1'b0;
    flush      = 1'b0;
    out_ready  = 1'b1;
    ready_mode = 0;
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;

    start_test();
    if (!in_ready) report_mismatch("in_ready_o", 1, in_ready);
    if (out_valid) report_mismatch("out_valid_o", 0, out_valid);
    if (busy) report_mismatch("busy_o", 0, busy);
    finish_test("reset state");

    start_test();
    for (int i = 0; i < N_SGNJ; i++) begin
      send(noncomp_op_e'({$random(seed)} % 3), FP32, 1'b0, 2'b11, $random(seed), $random(seed));
    end
    finish_test("fp32 sign injection");

    start_test();
    for (int f = 0; f < 2; f++) begin
      for (int o = 0; o < 2; o++) begin
        for (int i = 0; i < 8; i++) begin
          for (int j = 0; j < 8; j++) begin
            send(o ? MAXM : MINM, f ? FP16 : FP32, 1'b0, 2'b11,
                 special_value(f == 0, i), special_value(f == 0, j));
          end
        end
      end
    end
    finish_test("min/max specials");

    start_test();
    for (int i = 0; i < N_BOX; i++) begin
      a = $random(seed);
      b = $random(seed);
      if ({$random(seed)} % 2) a[31:16] = 16'hffff;  // Half of the operands boxed
      if ({$random(seed)} % 2) b[31:16] = 16'hffff;
      send(noncomp_op_e'({$random(seed)} % 5), FP16, 1'b0, 2'b11, a, b);
    end
    finish_test("fp16 scalar boxing");

    start_test();
    for (int i = 0; i < N_VEC; i++) begin
      v0 = special_value(1'b0, {$random(seed)} % 8);
      v1 = special_value(1'b0, {$random(seed)} % 8);
      v2 = special_value(1'b0, {$random(seed)} % 8);
      v3 = special_value(1'b0, {$random(seed)} % 8);
      send(noncomp_op_e'({$random(seed)} % 5), FP16, 1'b1, random_simd_mask(),
           {v1[15:0], v0[15:0]}, {v3[15:0], v2[15:0]});
    end
    finish_test("fp16 vectors");

    start_test();
    set_ready_mode(1);
    for (int i = 0; i < N_BP; i++) begin
      if ({$random(seed)} % 4 == 0) begin
        @(posedge clk);  // Input bubble
        #1;
      end
      send(noncomp_op_e'({$random(seed)} % 5), fp_format_e'({$random(seed)} % 2),
           {$random(seed)} % 2 == 1, 2'b11, $random(seed), $random(seed));
    end
    finish_test("back-pressure");

    start_test();
    set_ready_mode(0);
    for (int i = 0; i < N_LAT; i++) begin
      send(noncomp_op_e'({$random(seed)} % 5), FP32, 1'b0, 2'b11, $random(seed), $random(seed));
    end
    finish_test("latency");

    start_test();
    set_ready_mode(2);
    for (int i = 0; i < N_FLUSH; i++) begin
      send(MAXM, FP32, 1'b0, 2'b11, $random(seed), $random(seed));
    end
    flush = 1'b1;
    @(posedge clk);
    #1 flush = 1'b0;
    if (busy) report_mismatch("busy_o", 0, busy);
    if (out_valid) report_mismatch("out_valid_o", 0, out_valid);
    set_ready_mode(0);
    repeat (4) @(posedge clk);
    #1;
    finish_test("flush");

    if (n_checked != NUM_ITEMS - N_FLUSH) begin
      n_errors++;
      $display("Only %0d of %0d accepted items came out", n_checked, NUM_ITEMS - N_FLUSH);
    end
    $display("Summary: %0d tests, %0d items checked, %0d errors", n_tests, n_checked, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  function automatic lane_mask_t random_simd_mask();
    return lane_mask_t'({$random(seed)} % 4);  // Random SIMD mask
  endfunction

  initial begin : watchdog
    #((NUM_ITEMS * 20 + 10) * 100);
    $display("Timeout: run did not end within %0d cycles", NUM_ITEMS * 20 + 10);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
hdl/noncomp_pkg.sv
hdl/lane_splitter.sv
hdl/noncomp_lane.sv
hdl/lane_pipeline.sv
hdl/result_packer.sv
hdl/noncomp_slice.sv
testbench/tb_noncomp_slice.sv
